// File: common/ebusPkg.sv
`default_nettype none

// Bus-level definitions shared by the requester, the devices and the multiplexer
package ebusPkg;

  // EBUS words count bit 0 as the most significant bit, as on the KL10
  localparam int ebusWidth = 36;

  typedef logic [0:ebusWidth-1] ebusWord_t;

  // The four I/O functions an outside requester can put on the bus
  typedef enum logic [1:0] {
    funcConi,
    funcCono,
    funcDatai,
    funcDatao
  } ebusFunc_t;

  // Seven-bit device code carried with every command
  typedef logic [6:0] devCode_t;

  // CONI and DATAI make the addressed device drive the bus
  function automatic logic isRead(input ebusFunc_t func);
    return (func == funcConi) || (func == funcDatai);
  endfunction

endpackage

`default_nettype wire

// File: common/devicePkg.sv
`default_nettype none

// Definitions shared by the APR, PI and MTR devices
package devicePkg;

  // Level 0 means no level, 1 is the highest priority and 7 the lowest
  typedef logic [2:0] piLevel_t;

  // Bit i of a mask stands for level i+1
  typedef logic [6:0] piMask_t;

  // APR condition word, each field named by its least significant bit
  localparam int aprPiLevelLsb = 35;
  localparam int aprFlagLsb    = 26;
  localparam int aprEnableLsb  = 20;
  localparam int aprClearBit   = 22;

  // PI word, levels 1 to 7 sit in bits 29 to 35 and pending levels in 21 to 27
  localparam int piEnableLsb  = 35;
  localparam int piSysOnBit   = 28;
  localparam int piClearBit   = 27;
  localparam int piPendingLsb = 27;

  // MTR condition word and the interval field used by DATAO and DATAI
  localparam int mtrPiLevelLsb    = 35;
  localparam int mtrEnableBit     = 32;
  localparam int mtrDoneBit       = 31;
  localparam int mtrIntervalLsb   = 35;
  localparam int mtrIntervalWidth = 18;

  typedef enum logic [1:0] {
    mtrIdle,
    mtrCounting,
    mtrDone
  } mtrState_t;

  // One-hot request for an assigned level, empty when no level is assigned
  function automatic piMask_t levelMask(input piLevel_t level);
    piMask_t mask;
    mask = '0;
    if (level != '0) begin
      mask[level - 1'b1] = 1'b1;
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: logic/ebusMux.sv
`timescale 1ns/1ps
`default_nettype none

module ebusMux (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 cmdStrobe,
  input  wire ebusPkg::ebusFunc_t cmdFunc,
  input  wire                 aprDriving,
  input  wire ebusPkg::ebusWord_t aprData,
  input  wire                 piDriving,
  input  wire ebusPkg::ebusWord_t piData,
  input  wire                 mtrDriving,
  input  wire ebusPkg::ebusWord_t mtrData,
  output ebusPkg::ebusWord_t  ebusData,
  output logic                respStrobe,
  output logic                busConflict
);

  import ebusPkg::*;

  // Fixed priority APR, then PI, then MTR; an idle bus reads as zero
  always_comb begin
    if (aprDriving) begin
      ebusData = aprData;
    end else if (piDriving) begin
      ebusData = piData;
    end else if (mtrDriving) begin
      ebusData = mtrData;
    end else begin
      ebusData = '0;
    end
  end

  // Any pair of drivers at once is a conflict
  assign busConflict = (aprDriving && piDriving) ||
                       (aprDriving && mtrDriving) ||
                       (piDriving && mtrDriving);

  // Every read gets its response one cycle later, even if no device answers
  always_ff @(posedge clk) begin
    if (reset) begin
      respStrobe <= 1'b0;
    end else begin
      respStrobe <= cmdStrobe && isRead(cmdFunc);
    end
  end

  conflictCheck: assert property (@(posedge clk) disable iff (reset) !busConflict)
    else $error("EBUS conflict: apr=%0b pi=%0b mtr=%0b", aprDriving, piDriving, mtrDriving);

  // A device only drives in the response cycle of a read
  driveInRespCycle: assert property (@(posedge clk) disable iff (reset)
    (aprDriving || piDriving || mtrDriving) |-> respStrobe)
    else $error("Device drives the EBUS outside a response cycle");

endmodule

`default_nettype wire

// File: apr/aprDevice.sv
`timescale 1ns/1ps
`default_nettype none

module aprDevice #(
  parameter ebusPkg::devCode_t aprCode = 7'd0
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     cmdStrobe,
  input  wire ebusPkg::ebusFunc_t cmdFunc,
  input  wire ebusPkg::devCode_t  cmdDev,
  input  wire ebusPkg::ebusWord_t cmdData,
  input  wire                     sbusErr,
  input  wire                     nxmErr,
  input  wire                     parErr,
  output logic                    driving,
  output ebusPkg::ebusWord_t      driveData,
  output devicePkg::piMask_t      intRequest
);

  import ebusPkg::*;
  import devicePkg::*;

  logic       selected;
  logic       conoHit;
  logic       readHit;
  // Flag and enable fields are ordered sbus, nxm, parity from bit 2 down
  logic [2:0] flags;
  logic [2:0] enables;
  logic [2:0] errPulse;
  logic [2:0] clearMask;
  piLevel_t   level;
  ebusWord_t  condWord;

  assign selected = cmdStrobe && (cmdDev == aprCode);
  assign conoHit  = selected && (cmdFunc == funcCono);
  assign readHit  = selected && isRead(cmdFunc);
  assign errPulse = {sbusErr, nxmErr, parErr};

  // CONO with the clear bit clears exactly the flags written as one
  assign clearMask = (conoHit && cmdData[aprClearBit]) ? cmdData[aprFlagLsb-2 +: 3] : 3'b000;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags   <= '0;
      enables <= '0;
      level   <= '0;
    end else begin
      // An error on the same edge as a clear still sets its flag
      flags <= (flags & ~clearMask) | errPulse;
      if (conoHit) begin
        enables <= cmdData[aprEnableLsb-2 +: 3];
        level   <= cmdData[aprPiLevelLsb-2 +: 3];
      end
    end
  end

  always_comb begin
    condWord = '0;
    condWord[aprEnableLsb-2 +: 3]  = enables;
    condWord[aprFlagLsb-2 +: 3]    = flags;
    condWord[aprPiLevelLsb-2 +: 3] = level;
  end

  // The APR has no data register, so DATAI returns the condition word too
  always_ff @(posedge clk) begin
    if (reset) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      driveData <= condWord;
    end
  end

  assign intRequest = (|(flags & enables)) ? levelMask(level) : '0;

  // A read of the APR drives the bus for a single cycle
  singleDrive: assert property (@(posedge clk) disable iff (reset)
    driving |=> !driving)
    else $error("APR drove the EBUS for two cycles in a row");

endmodule

`default_nettype wire

// File: pi/piDevice.sv
`timescale 1ns/1ps
`default_nettype none

module piDevice #(
  parameter ebusPkg::devCode_t piCode = 7'd1
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     cmdStrobe,
  input  wire ebusPkg::ebusFunc_t cmdFunc,
  input  wire ebusPkg::devCode_t  cmdDev,
  input  wire ebusPkg::ebusWord_t cmdData,
  input  wire devicePkg::piMask_t aprRequest,
  input  wire devicePkg::piMask_t mtrRequest,
  output logic                    driving,
  output ebusPkg::ebusWord_t      driveData,
  output devicePkg::piLevel_t     piActive
);

  import ebusPkg::*;
  import devicePkg::*;

  logic      selected;
  logic      conoHit;
  logic      readHit;
  logic      sysOn;
  piMask_t   enables;
  piMask_t   cmdEnables;
  piMask_t   pending;
  piMask_t   active;
  piLevel_t  nextActive;
  ebusWord_t condWord;

  assign selected = cmdStrobe && (cmdDev == piCode);
  assign conoHit  = selected && (cmdFunc == funcCono);
  assign readHit  = selected && isRead(cmdFunc);

  // Level 1 sits in bit 29 and level 7 in bit 35, so the mask is reversed
  always_comb begin
    for (int i = 0; i < 7; i++) begin
      cmdEnables[i] = cmdData[piEnableLsb - 6 + i];
    end
  end

  assign pending = aprRequest | mtrRequest;
  assign active  = pending & enables & {7{sysOn}};

  // Lowest-numbered level wins, so scan from level 7 up to level 1
  always_comb begin
    nextActive = '0;
    for (int i = 6; i >= 0; i--) begin
      if (active[i]) begin
        nextActive = piLevel_t'(i + 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enables  <= '0;
      sysOn    <= 1'b0;
      piActive <= '0;
    end else begin
      piActive <= nextActive;
      if (conoHit) begin
        sysOn <= cmdData[piSysOnBit];
        // Written enables add to the current set unless clear-all comes with them
        if (cmdData[piClearBit]) begin
          enables <= cmdEnables;
        end else begin
          enables <= enables | cmdEnables;
        end
      end
    end
  end

  always_comb begin
    condWord = '0;
    condWord[piSysOnBit] = sysOn;
    for (int i = 0; i < 7; i++) begin
      condWord[piEnableLsb - 6 + i]  = enables[i];
      condWord[piPendingLsb - 6 + i] = pending[i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      driveData <= condWord;
    end
  end

  // With the system off, the next registered level must be none
  sysOffQuiet: assert property (@(posedge clk) disable iff (reset)
    !sysOn |=> (piActive == '0))
    else $error("PI reports level %0d with the system off", piActive);

endmodule

`default_nettype wire

// File: mtr/mtrDevice.sv
`timescale 1ns/1ps
`default_nettype none

module mtrDevice #(
  parameter ebusPkg::devCode_t mtrCode = 7'd2
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     cmdStrobe,
  input  wire ebusPkg::ebusFunc_t cmdFunc,
  input  wire ebusPkg::devCode_t  cmdDev,
  input  wire ebusPkg::ebusWord_t cmdData,
  output logic                    driving,
  output ebusPkg::ebusWord_t      driveData,
  output devicePkg::piMask_t      intRequest
);

  import ebusPkg::*;
  import devicePkg::*;

  localparam int intervalFirst = mtrIntervalLsb - mtrIntervalWidth + 1;

  logic                        selected;
  logic                        conoHit;
  logic                        dataoHit;
  logic                        readHit;
  logic                        enable;
  logic                        wrap;
  logic [mtrIntervalWidth-1:0] interval;
  logic [mtrIntervalWidth-1:0] counter;
  piLevel_t                    level;
  mtrState_t                   state;
  mtrState_t                   nextState;
  ebusWord_t                   condWord;
  ebusWord_t                   dataWord;

  assign selected = cmdStrobe && (cmdDev == mtrCode);
  assign conoHit  = selected && (cmdFunc == funcCono);
  assign dataoHit = selected && (cmdFunc == funcDatao);
  assign readHit  = selected && isRead(cmdFunc);

  assign wrap = enable && (counter == interval);

  always_comb begin
    nextState = state;
    case (state)
      mtrIdle: begin
        if (conoHit && cmdData[mtrEnableBit]) begin
          nextState = mtrCounting;
        end
      end
      mtrCounting: begin
        if (conoHit && !cmdData[mtrEnableBit]) begin
          nextState = mtrIdle;
        end else if (wrap) begin
          nextState = mtrDone;
        end
      end
      mtrDone: begin
        // Done stays until software writes the done bit as one
        if (conoHit && cmdData[mtrDoneBit]) begin
          nextState = cmdData[mtrEnableBit] ? mtrCounting : mtrIdle;
        end
      end
      default: nextState = mtrIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mtrIdle;
      enable   <= 1'b0;
      level    <= '0;
      interval <= '0;
      counter  <= '0;
    end else begin
      state <= nextState;
      if (conoHit) begin
        enable <= cmdData[mtrEnableBit];
        level  <= cmdData[mtrPiLevelLsb-2 +: 3];
      end
      // A new interval restarts the count so it never starts above the limit
      if (dataoHit) begin
        interval <= cmdData[intervalFirst +: mtrIntervalWidth];
        counter  <= '0;
      end else if (wrap) begin
        counter <= '0;
      end else if (enable) begin
        counter <= counter + 1'b1;
      end
    end
  end

  always_comb begin
    condWord = '0;
    condWord[mtrDoneBit]              = (state == mtrDone);
    condWord[mtrEnableBit]            = enable;
    condWord[mtrPiLevelLsb-2 +: 3]    = level;
    dataWord = '0;
    dataWord[intervalFirst +: mtrIntervalWidth] = counter;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      driveData <= (cmdFunc == funcDatai) ? dataWord : condWord;
    end
  end

  assign intRequest = (state == mtrDone) ? levelMask(level) : '0;

  counterInRange: assert property (@(posedge clk) disable iff (reset) counter <= interval)
    else $error("MTR counter %0d passed interval %0d", counter, interval);

endmodule

`default_nettype wire

// File: logic/ebusSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ebusSubsystem #(
  parameter ebusPkg::devCode_t aprCode = 7'd0,
  parameter ebusPkg::devCode_t piCode  = 7'd1,
  parameter ebusPkg::devCode_t mtrCode = 7'd2
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     cmdStrobe,
  input  wire ebusPkg::ebusFunc_t cmdFunc,
  input  wire ebusPkg::devCode_t  cmdDev,
  input  wire ebusPkg::ebusWord_t cmdData,
  input  wire                     sbusErr,
  input  wire                     nxmErr,
  input  wire                     parErr,
  output ebusPkg::ebusWord_t      ebusData,
  output logic                    respStrobe,
  output logic                    busConflict,
  output devicePkg::piLevel_t     piActive
);

  import ebusPkg::*;
  import devicePkg::*;

  logic      aprDriving;
  logic      piDriving;
  logic      mtrDriving;
  ebusWord_t aprData;
  ebusWord_t piData;
  ebusWord_t mtrData;
  piMask_t   aprRequest;
  piMask_t   mtrRequest;

  aprDevice #(.aprCode(aprCode)) i_aprDevice (
    .clk        (clk),
    .reset      (reset),
    .cmdStrobe  (cmdStrobe),
    .cmdFunc    (cmdFunc),
    .cmdDev     (cmdDev),
    .cmdData    (cmdData),
    .sbusErr    (sbusErr),
    .nxmErr     (nxmErr),
    .parErr     (parErr),
    .driving    (aprDriving),
    .driveData  (aprData),
    .intRequest (aprRequest)
  );

  // Interrupt requests from the peers meet in the PI
  piDevice #(.piCode(piCode)) i_piDevice (
    .clk        (clk),
    .reset      (reset),
    .cmdStrobe  (cmdStrobe),
    .cmdFunc    (cmdFunc),
    .cmdDev     (cmdDev),
    .cmdData    (cmdData),
    .aprRequest (aprRequest),
    .mtrRequest (mtrRequest),
    .driving    (piDriving),
    .driveData  (piData),
    .piActive   (piActive)
  );

  mtrDevice #(.mtrCode(mtrCode)) i_mtrDevice (
    .clk        (clk),
    .reset      (reset),
    .cmdStrobe  (cmdStrobe),
    .cmdFunc    (cmdFunc),
    .cmdDev     (cmdDev),
    .cmdData    (cmdData),
    .driving    (mtrDriving),
    .driveData  (mtrData),
    .intRequest (mtrRequest)
  );

  ebusMux i_ebusMux (
    .clk         (clk),
    .reset       (reset),
    .cmdStrobe   (cmdStrobe),
    .cmdFunc     (cmdFunc),
    .aprDriving  (aprDriving),
    .aprData     (aprData),
    .piDriving   (piDriving),
    .piData      (piData),
    .mtrDriving  (mtrDriving),
    .mtrData     (mtrData),
    .ebusData    (ebusData),
    .respStrobe  (respStrobe),
    .busConflict (busConflict)
  );

endmodule

`default_nettype wire

// File: verification/ebusTb.sv
`timescale 1ns/1ps
`default_nettype none

module ebusTb;

  import ebusPkg::*;
  import devicePkg::*;

  localparam devCode_t aprCode    = 7'd0;
  localparam devCode_t piCode     = 7'd1;
  localparam devCode_t mtrCode    = 7'd2;
  localparam devCode_t unusedCode = 7'd100;

  localparam int numTests        = 5;
  localparam int respLimit       = 4;
  localparam int pollLimit       = 40;
  localparam int longestInterval = 20;
  // A poll is a whole bus read, so each counted MTR cycle may cost several clocks
  localparam int watchdogCycles  = numTests * longestInterval * 10 + 100;

  logic      clk = 1'b0;
  logic      reset;
  logic      cmdStrobe;
  ebusFunc_t cmdFunc;
  devCode_t  cmdDev;
  ebusWord_t cmdData;
  logic      sbusErr;
  logic      nxmErr;
  logic      parErr;
  ebusWord_t ebusData;
  logic      respStrobe;
  logic      busConflict;
  piLevel_t  piActive;

  integer     seed = 32'h0c2b_30f0;
  int         errorCount = 0;
  int         checkCount = 0;
  int         failedTests = 0;
  int         errorsAtStart;
  string      testName;
  ebusWord_t  readData;
  logic       readConflict;
  int         readLatency;
  logic [2:0] aprEnables;
  piLevel_t   aprLevel;

  ebusSubsystem #(
    .aprCode (aprCode),
    .piCode  (piCode),
    .mtrCode (mtrCode)
  ) i_ebusSubsystem (
    .clk         (clk),
    .reset       (reset),
    .cmdStrobe   (cmdStrobe),
    .cmdFunc     (cmdFunc),
    .cmdDev      (cmdDev),
    .cmdData     (cmdData),
    .sbusErr     (sbusErr),
    .nxmErr      (nxmErr),
    .parErr      (parErr),
    .ebusData    (ebusData),
    .respStrobe  (respStrobe),
    .busConflict (busConflict),
    .piActive    (piActive)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("Test failures found");
    $finish;
  end

  // APR condition word: enables 18-20, flags 24-26 as sbus, nxm, parity, level 33-35
  function automatic ebusWord_t aprCondWord(input logic [2:0] enables, input logic [2:0] flags,
                                            input piLevel_t level, input logic clear);
    ebusWord_t w;
    w = '0;
    w[18:20] = enables;
    w[22] = clear;
    w[24:26] = flags;
    w[33:35] = level;
    return w;
  endfunction

  // Level L enable sits in bit 28+L
  function automatic ebusWord_t piConoWord(input piMask_t levels, input logic sysOn,
                                           input logic clearAll);
    ebusWord_t w;
    w = '0;
    w[27] = clearAll;
    w[28] = sysOn;
    for (int i = 0; i < 7; i++) begin
      w[29 + i] = levels[i];
    end
    return w;
  endfunction

  function automatic ebusWord_t piConiWord(input piMask_t levels, input logic sysOn,
                                           input piMask_t pending);
    ebusWord_t w;
    w = '0;
    w[28] = sysOn;
    for (int i = 0; i < 7; i++) begin
      w[29 + i] = levels[i];
      w[21 + i] = pending[i];
    end
    return w;
  endfunction

  function automatic ebusWord_t mtrCondWord(input piLevel_t level, input logic enable,
                                            input logic done);
    ebusWord_t w;
    w = '0;
    w[31] = done;
    w[32] = enable;
    w[33:35] = level;
    return w;
  endfunction

  function automatic ebusWord_t intervalWord(input logic [17:0] value);
    ebusWord_t w;
    w = '0;
    w[18:35] = value;
    return w;
  endfunction

  task automatic checkWord(input string label, input ebusWord_t expected, input ebusWord_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s: expected %h actual %h", testName, label, expected, actual);
    end
  endtask

  task automatic checkLevel(input string label, input piLevel_t expected, input piLevel_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s: expected %0d actual %0d", testName, label, expected, actual);
    end
  endtask

  task automatic checkBit(input string label, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s: expected %b actual %b", testName, label, expected, actual);
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic busWrite(input ebusFunc_t func, input devCode_t dev, input ebusWord_t data);
    @(negedge clk);
    cmdStrobe = 1'b1;
    cmdFunc   = func;
    cmdDev    = dev;
    cmdData   = data;
    @(negedge clk);
    cmdStrobe = 1'b0;
  endtask

  // Latency counts clock edges from the strobe to the response
  task automatic busRead(input ebusFunc_t func, input devCode_t dev);
    @(negedge clk);
    cmdStrobe = 1'b1;
    cmdFunc   = func;
    cmdDev    = dev;
    cmdData   = '0;
    @(negedge clk);
    cmdStrobe = 1'b0;
    readLatency = 1;
    while (!respStrobe && readLatency < respLimit) begin
      @(negedge clk);
      readLatency++;
    end
    if (!respStrobe) begin
      errorCount++;
      $display("Error in %s: no respStrobe within %0d cycles of a read", testName, respLimit);
    end
    readData     = ebusData;
    readConflict = busConflict;
  endtask

  // Bits are ordered sbus, nxm, parity
  task automatic pulseError(input logic [2:0] which);
    @(negedge clk);
    {sbusErr, nxmErr, parErr} = which;
    @(negedge clk);
    {sbusErr, nxmErr, parErr} = 3'b000;
  endtask

  task automatic pollMtrDone(output logic done);
    int polls;
    done  = 1'b0;
    polls = 0;
    while (!done && polls < pollLimit) begin
      busRead(funcConi, mtrCode);
      done = readData[31];
      polls++;
    end
    if (!done) begin
      errorCount++;
      $display("Error in %s: MTR done not set within %0d polls", testName, pollLimit);
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    if (errorCount == errorsAtStart) begin
      $display("%s: ok", testName);
    end else begin
      failedTests++;
      $display("%s: %0d errors", testName, errorCount - errorsAtStart);
    end
  endtask

  task automatic aprRoundTrip();
    startTest("apr round trip");
    aprEnables = 3'($random(seed));
    aprLevel   = 3'($random(seed));
    busWrite(funcCono, aprCode, aprCondWord(aprEnables, 3'b000, aprLevel, 1'b0));
    busRead(funcConi, aprCode);
    checkWord("coni", aprCondWord(aprEnables, 3'b000, aprLevel, 1'b0), readData);
    checkBit("bus conflict", 1'b0, readConflict);
    finishTest();
  endtask

  task automatic aprFlags();
    startTest("apr flags");
    pulseError(3'b010);
    pulseError(3'b001);
    busRead(funcConi, aprCode);
    checkWord("both flags", aprCondWord(aprEnables, 3'b011, aprLevel, 1'b0), readData);
    // This CONO also rewrites enables and level to zero
    busWrite(funcCono, aprCode, aprCondWord(3'b000, 3'b010, 3'd0, 1'b1));
    busRead(funcConi, aprCode);
    checkWord("parity left", aprCondWord(3'b000, 3'b001, 3'd0, 1'b0), readData);
    busWrite(funcCono, aprCode, aprCondWord(3'b000, 3'b111, 3'd0, 1'b1));
    busRead(funcConi, aprCode);
    checkWord("all clear", '0, readData);
    finishTest();
  endtask

  task automatic mtrTimer();
    logic        done;
    logic [17:0] count;
    startTest("mtr timer");
    busWrite(funcDatao, mtrCode, intervalWord(18'd20));
    busWrite(funcCono, mtrCode, mtrCondWord(3'd0, 1'b1, 1'b0));
    pollMtrDone(done);
    checkBit("done seen", 1'b1, done);
    checkWord("coni at done", mtrCondWord(3'd0, 1'b1, 1'b1), readData);
    busRead(funcDatai, mtrCode);
    count = readData[18:35];
    checkBit("count within interval", 1'b1, count <= 18'd20);
    busWrite(funcCono, mtrCode, mtrCondWord(3'd0, 1'b0, 1'b1));
    busRead(funcConi, mtrCode);
    checkWord("coni after clear", mtrCondWord(3'd0, 1'b0, 1'b0), readData);
    finishTest();
  endtask

  task automatic piPriority();
    logic done;
    startTest("pi priority");
    // Levels 3 and 5 are mask bits 2 and 4
    busWrite(funcCono, piCode, piConoWord(7'b0010100, 1'b1, 1'b1));
    busWrite(funcCono, aprCode, aprCondWord(3'b010, 3'b000, 3'd5, 1'b0));
    pulseError(3'b010);
    waitCycles(2);
    checkLevel("apr level", 3'd5, piActive);
    busWrite(funcDatao, mtrCode, intervalWord(18'd10));
    busWrite(funcCono, mtrCode, mtrCondWord(3'd3, 1'b1, 1'b0));
    pollMtrDone(done);
    checkBit("mtr done", 1'b1, done);
    waitCycles(2);
    checkLevel("mtr level", 3'd3, piActive);
    busRead(funcConi, piCode);
    checkWord("pi coni", piConiWord(7'b0010100, 1'b1, 7'b0010100), readData);
    busWrite(funcCono, piCode, piConoWord(7'b0000000, 1'b0, 1'b0));
    waitCycles(2);
    checkLevel("system off", 3'd0, piActive);
    finishTest();
  endtask

  task automatic unassignedDevice();
    ebusWord_t noise;
    startTest("unassigned device");
    busRead(funcConi, unusedCode);
    checkBit("one cycle response", 1'b1, readLatency == 1);
    checkWord("idle bus", '0, readData);
    waitCycles(1);
    checkBit("single response", 1'b0, respStrobe);
    noise = {4'($random(seed)), 32'($random(seed))};
    busWrite(funcCono, unusedCode, noise);
    busRead(funcConi, aprCode);
    checkWord("apr unchanged", aprCondWord(3'b010, 3'b010, 3'd5, 1'b0), readData);
    busRead(funcConi, piCode);
    checkWord("pi unchanged", piConiWord(7'b0010100, 1'b0, 7'b0010100), readData);
    busRead(funcConi, mtrCode);
    checkWord("mtr unchanged", mtrCondWord(3'd3, 1'b1, 1'b1), readData);
    finishTest();
  endtask

  initial begin
    reset     = 1'b1;
    cmdStrobe = 1'b0;
    cmdFunc   = funcConi;
    cmdDev    = '0;
    cmdData   = '0;
    sbusErr   = 1'b0;
    nxmErr    = 1'b0;
    parErr    = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    aprRoundTrip();
    aprFlags();
    mtrTimer();
    piPriority();
    unassignedDevice();
    $display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             numTests, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/ebusPkg.sv
common/devicePkg.sv
logic/ebusMux.sv
apr/aprDevice.sv
pi/piDevice.sv
mtr/mtrDevice.sv
logic/ebusSubsystem.sv
verification/ebusTb.sv

// File: run.sh
#!/bin/sh
# Build and run the EBUS testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module ebusTb -f tb.f -o ebusSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/ebusSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF "All tests passed!"; then
  exit 0
fi
exit 1
